// ==== design/controller_pkg.sv ====
// Shared types and widths for the standby target; imported by the engine, writer and top level
`default_nettype none

package controller_pkg;

  // Descriptor word as pushed into the RX descriptor queue
  localparam int RxDescWidth = 32;

  // Bus-side data byte counter
  localparam int ByteCountWidth = 16;

  // Meaning of the ninth bit of each data byte
  typedef enum logic {
    i2c_mode = 1'b0,
    i3c_mode = 1'b1
  } bus_mode_e;

  // One entry per completed write transfer
  typedef struct packed {
    logic                      err_overrun;
    logic                      err_parity;
    logic [6:0]                reserved;
    logic [6:0]                addr;
    logic [ByteCountWidth-1:0] byte_count;
  } rx_desc_t;

endpackage

`default_nettype wire

// ==== design/bus_event_if.sv ====
// Decoded bus conditions, driven by the bus monitor and consumed by the target engine
`default_nettype none
`timescale 1ns/1ps

interface bus_event_if;

  // All strobes are single-cycle pulses
  logic start;
  logic stop;
  logic bit_valid;
  logic bit_value;
  logic scl_fall;

  modport mon (
    output start,
    output stop,
    output bit_valid,
    output bit_value,
    output scl_fall
  );

  modport fsm (
    input start,
    input stop,
    input bit_valid,
    input bit_value,
    input scl_fall
  );

endinterface

`default_nettype wire

// ==== design/rx_byte_if.sv ====
// Valid/ready channel for received bytes and end-of-transfer items, engine to queue writer
`default_nettype none
`timescale 1ns/1ps

interface rx_byte_if;
  import controller_pkg::*;

  logic                      valid;
  logic                      ready;
  logic [7:0]                data;
  // Set on the end-of-transfer item, which carries no data byte
  logic                      last;
  logic                      overrun;
  logic                      parity_err;
  logic [6:0]                addr;
  logic [ByteCountWidth-1:0] byte_count;

  modport src (
    output valid, data, last, overrun, parity_err, addr, byte_count,
    input  ready
  );

  modport dst (
    input  valid, data, last, overrun, parity_err, addr, byte_count,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/bus_monitor.sv ====
// Synchronizes SCL/SDA and turns their edges into START, STOP, bit and SCL-fall pulses
`default_nettype none
`timescale 1ns/1ps

module bus_monitor #(
  parameter int SyncStages = 2
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     scl_i,
  input  logic     sda_i,
  bus_event_if.mon ev_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_prev_q;
  logic                  sda_prev_q;
  logic                  start_q;
  logic                  stop_q;
  logic                  rise_q;
  logic                  fall_q;
  logic                  bit_q;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // Idle bus is high, so the chains come out of reset at 1
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      start_q    <= 1'b0;
      stop_q     <= 1'b0;
      rise_q     <= 1'b0;
      fall_q     <= 1'b0;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      // SDA edges only count while SCL stays high
      start_q    <= scl_prev_q && scl_s && sda_prev_q && !sda_s;
      stop_q     <= scl_prev_q && scl_s && !sda_prev_q && sda_s;
      rise_q     <= !scl_prev_q && scl_s;
      fall_q     <= scl_prev_q && !scl_s;
    end
  end

  // Sampled level, qualified by bit_valid
  always_ff @(posedge clk_i) begin
    bit_q <= sda_s;
  end

  assign ev_o.start     = start_q;
  assign ev_o.stop      = stop_q;
  assign ev_o.bit_valid = rise_q;
  assign ev_o.bit_value = bit_q;
  assign ev_o.scl_fall  = fall_q;

endmodule

`default_nettype wire

// ==== design/target_fsm.sv ====
// Target engine: address match, ACK drive with hold time, I3C T-bit check and RX byte buffering
`default_nettype none
`timescale 1ns/1ps

module target_fsm (
  input  logic                      clk_i,
  input  logic                      rst_i,
  bus_event_if.fsm                  ev_i,
  input  controller_pkg::bus_mode_e mode_i,
  input  logic [6:0]                target_addr_i,
  input  logic [19:0]               t_hd_dat_i,
  output logic                      sda_o,
  output logic                      bus_start_o,
  output logic                      bus_stop_o,
  output logic [7:0]                bus_addr_o,
  output logic                      bus_addr_valid_o,
  rx_byte_if.src                    rx_o
);
  import controller_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_addr_ack,
    st_data,
    st_ninth,
    st_ignore
  } state_e;

  state_e                    state_q;
  logic [7:0]                shreg_q;
  logic [2:0]                bit_cnt_q;
  logic [7:0]                byte_w;
  logic                      addr_done;
  logic                      addr_hit;
  logic                      ninth_done;
  logic                      parity_bad;
  logic                      end_xfer;
  logic                      buf_free;
  logic                      byte_load;
  logic                      last_load;
  logic                      xfer_q;
  logic                      last_pend_q;
  logic                      arm_q;
  logic                      sda_tgt_q;
  logic                      hd_run_q;
  logic [19:0]               hd_cnt_q;
  logic [6:0]                addr_q;
  logic [ByteCountWidth-1:0] byte_cnt_q;
  logic                      overrun_q;
  logic                      parity_err_q;
  logic                      buf_valid_q;
  logic [7:0]                buf_data_q;
  logic                      buf_last_q;
  logic                      buf_ovr_q;
  logic                      buf_par_q;
  logic [6:0]                buf_addr_q;
  logic [ByteCountWidth-1:0] buf_cnt_q;

  assign byte_w     = {shreg_q[6:0], ev_i.bit_value};
  assign addr_done  = (state_q == st_addr) && ev_i.bit_valid && (bit_cnt_q == 3'd7);
  assign addr_hit   = addr_done && (byte_w[7:1] == target_addr_i) && !byte_w[0];
  assign ninth_done = (state_q == st_ninth) && ev_i.bit_valid;
  // T-bit makes the nine bits odd
  assign parity_bad = (mode_i == i3c_mode) && (ev_i.bit_value == ^shreg_q);
  assign end_xfer   = xfer_q && (ev_i.start || ev_i.stop);
  // Single buffer slot; a byte arriving while it is taken is dropped
  assign buf_free   = !buf_valid_q || rx_o.ready;
  assign last_load  = last_pend_q && buf_free;
  assign byte_load  = ninth_done && buf_free && !last_pend_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q          <= st_idle;
      bit_cnt_q        <= '0;
      xfer_q           <= 1'b0;
      last_pend_q      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      arm_q            <= 1'b0;
      sda_tgt_q        <= 1'b1;
      hd_run_q         <= 1'b0;
      hd_cnt_q         <= '0;
      sda_o            <= 1'b1;
      buf_valid_q      <= 1'b0;
      byte_cnt_q       <= '0;
      overrun_q        <= 1'b0;
      parity_err_q     <= 1'b0;
    end else begin
      bus_addr_valid_o <= addr_done;
      buf_valid_q      <= byte_load || last_load || (buf_valid_q && !rx_o.ready);

      if (end_xfer) begin
        last_pend_q <= 1'b1;
      end else if (last_load) begin
        last_pend_q <= 1'b0;
      end

      if (last_load) begin
        byte_cnt_q   <= '0;
        overrun_q    <= 1'b0;
        parity_err_q <= 1'b0;
      end else if (ninth_done) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
        if (!byte_load) begin
          overrun_q <= 1'b1;
        end
        if (parity_bad) begin
          parity_err_q <= 1'b1;
        end
      end

      if (ev_i.start) begin
        state_q   <= st_addr;
        bit_cnt_q <= '0;
        xfer_q    <= 1'b0;
      end else if (ev_i.stop) begin
        state_q <= st_idle;
        xfer_q  <= 1'b0;
      end else if (ev_i.bit_valid) begin
        case (state_q)
          st_addr: begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (addr_done) begin
              state_q   <= addr_hit ? st_addr_ack : st_ignore;
              xfer_q    <= addr_hit;
              arm_q     <= addr_hit;
              sda_tgt_q <= 1'b0;
            end
          end
          st_addr_ack: begin
            state_q   <= st_data;
            bit_cnt_q <= '0;
            arm_q     <= 1'b1;
            sda_tgt_q <= 1'b1;
          end
          st_data: begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= st_ninth;
              if (mode_i == i2c_mode) begin
                arm_q     <= 1'b1;
                sda_tgt_q <= 1'b0;
              end
            end
          end
          st_ninth: begin
            state_q   <= st_data;
            bit_cnt_q <= '0;
            if (mode_i == i2c_mode) begin
              arm_q     <= 1'b1;
              sda_tgt_q <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end

      // SDA changes t_hd_dat_i cycles after the armed SCL fall, at least one
      if (ev_i.start || ev_i.stop) begin
        arm_q    <= 1'b0;
        hd_run_q <= 1'b0;
        sda_o    <= 1'b1;
      end else if (arm_q && ev_i.scl_fall) begin
        arm_q <= 1'b0;
        if (t_hd_dat_i <= 20'd1) begin
          sda_o <= sda_tgt_q;
        end else begin
          hd_run_q <= 1'b1;
          hd_cnt_q <= t_hd_dat_i - 20'd1;
        end
      end else if (hd_run_q) begin
        if (hd_cnt_q == 20'd1) begin
          sda_o    <= sda_tgt_q;
          hd_run_q <= 1'b0;
        end else begin
          hd_cnt_q <= hd_cnt_q - 20'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ev_i.bit_valid && (state_q == st_addr || state_q == st_data)) begin
      shreg_q <= byte_w;
    end
    if (addr_done) begin
      bus_addr_o <= byte_w;
    end
    if (addr_hit) begin
      addr_q <= byte_w[7:1];
    end
    if (byte_load) begin
      buf_data_q <= shreg_q;
      buf_last_q <= 1'b0;
    end
    // End item snapshots the transfer status
    if (last_load) begin
      buf_data_q <= '0;
      buf_last_q <= 1'b1;
      buf_ovr_q  <= overrun_q;
      buf_par_q  <= parity_err_q;
      buf_addr_q <= addr_q;
      buf_cnt_q  <= byte_cnt_q;
    end
  end

  assign bus_start_o     = ev_i.start;
  assign bus_stop_o      = ev_i.stop;
  assign rx_o.valid      = buf_valid_q;
  assign rx_o.data       = buf_data_q;
  assign rx_o.last       = buf_last_q;
  assign rx_o.overrun    = buf_ovr_q;
  assign rx_o.parity_err = buf_par_q;
  assign rx_o.addr       = buf_addr_q;
  assign rx_o.byte_count = buf_cnt_q;

endmodule

`default_nettype wire

// ==== design/rx_queue_writer.sv ====
// Pushes received bytes into the RX data queue and one descriptor per transfer into its queue
`default_nettype none
`timescale 1ns/1ps

module rx_queue_writer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  rx_byte_if.dst                   rx_i,
  output logic                     rx_queue_wvalid_o,
  output logic [7:0]               rx_queue_wdata_o,
  input  logic                     rx_queue_wready_i,
  output logic                     rx_desc_queue_wvalid_o,
  output controller_pkg::rx_desc_t rx_desc_queue_wdata_o,
  input  logic                     rx_desc_queue_wready_i
);
  import controller_pkg::*;

  logic                   dq_valid_q;
  logic [7:0]             dq_data_q;
  logic                   desc_valid_q;
  logic [RxDescWidth-1:0] desc_q;
  logic                   data_acc;
  logic                   last_acc;
  rx_desc_t               desc_w;

  // End item waits for the data register to drain, so the descriptor
  // always follows the transfer's last byte
  assign rx_i.ready = !dq_valid_q &&
                      (rx_i.last ? !desc_valid_q : rx_queue_wready_i);

  assign data_acc = rx_i.valid && rx_i.ready && !rx_i.last;
  assign last_acc = rx_i.valid && rx_i.ready && rx_i.last;

  always_comb begin
    desc_w             = '0;
    desc_w.err_overrun = rx_i.overrun;
    desc_w.err_parity  = rx_i.parity_err;
    desc_w.addr        = rx_i.addr;
    // Bus-side count, dropped bytes included
    desc_w.byte_count  = rx_i.byte_count;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dq_valid_q   <= 1'b0;
      desc_valid_q <= 1'b0;
    end else begin
      if (data_acc) begin
        dq_valid_q <= 1'b1;
      end else if (rx_queue_wready_i) begin
        dq_valid_q <= 1'b0;
      end

      if (last_acc) begin
        desc_valid_q <= 1'b1;
      end else if (rx_desc_queue_wready_i) begin
        desc_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_acc) begin
      dq_data_q <= rx_i.data;
    end
    if (last_acc) begin
      desc_q <= desc_w;
    end
  end

  assign rx_queue_wvalid_o      = dq_valid_q;
  assign rx_queue_wdata_o       = dq_data_q;
  assign rx_desc_queue_wvalid_o = desc_valid_q;
  assign rx_desc_queue_wdata_o  = rx_desc_t'(desc_q);

endmodule

`default_nettype wire

// ==== design/controller_standby.sv ====
// Top of the standby I2C/I3C write target; connects bus monitor, engine and queue writer
`default_nettype none
`timescale 1ns/1ps

module controller_standby #(
  parameter int SyncStages = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Bus pins, SDA is open drain
  input  logic                                 ctrl_scl_i,
  input  logic                                 ctrl_sda_i,
  output logic                                 ctrl_sda_o,

  input  logic                                 i3c_en_i,
  input  logic [6:0]                           target_addr_i,
  input  logic [19:0]                          t_hd_dat_i,

  // RX data queue
  output logic                                 rx_queue_wvalid_o,
  input  logic                                 rx_queue_wready_i,
  output logic [7:0]                           rx_queue_wdata_o,

  // RX descriptor queue
  output logic                                 rx_desc_queue_wvalid_o,
  input  logic                                 rx_desc_queue_wready_i,
  output logic [controller_pkg::RxDescWidth-1:0] rx_desc_queue_wdata_o,

  // Bus condition and address report
  output logic                                 bus_start_o,
  output logic                                 bus_stop_o,
  output logic [7:0]                           bus_addr_o,
  output logic                                 bus_addr_valid_o
);
  import controller_pkg::*;

  bus_event_if bus_ev ();
  rx_byte_if   rx_byte ();

  bus_monitor #(
    .SyncStages(SyncStages)
  ) u_bus_monitor (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .scl_i(ctrl_scl_i),
    .sda_i(ctrl_sda_i),
    .ev_o (bus_ev)
  );

  target_fsm u_target_fsm (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ev_i            (bus_ev),
    .mode_i          (bus_mode_e'(i3c_en_i)),
    .target_addr_i   (target_addr_i),
    .t_hd_dat_i      (t_hd_dat_i),
    .sda_o           (ctrl_sda_o),
    .bus_start_o     (bus_start_o),
    .bus_stop_o      (bus_stop_o),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .rx_o            (rx_byte)
  );

  rx_queue_writer u_rx_queue_writer (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .rx_i                  (rx_byte),
    .rx_queue_wvalid_o     (rx_queue_wvalid_o),
    .rx_queue_wdata_o      (rx_queue_wdata_o),
    .rx_queue_wready_i     (rx_queue_wready_i),
    .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o (rx_desc_queue_wdata_o),
    .rx_desc_queue_wready_i(rx_desc_queue_wready_i)
  );

endmodule

`default_nettype wire

// ==== tests/controller_standby_asserts.sv ====
// Concurrent checks on the queue handshakes and SDA reset level, bound to the top level
`default_nettype none
`timescale 1ns/1ps

module controller_standby_asserts (
  input wire        clk_i,
  input wire        rst_i,
  input wire        ctrl_sda_o,
  input wire        rx_queue_wvalid_o,
  input wire        rx_queue_wready_i,
  input wire [7:0]  rx_queue_wdata_o,
  input wire        rx_desc_queue_wvalid_o,
  input wire        rx_desc_queue_wready_i,
  input wire [31:0] rx_desc_queue_wdata_o
);

  // Data queue holds valid and payload while stalled
  data_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_queue_wvalid_o && !rx_queue_wready_i |=>
      rx_queue_wvalid_o && $stable(rx_queue_wdata_o))
    else $error("data queue valid or payload changed while stalled");

  desc_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_desc_queue_wvalid_o && !rx_desc_queue_wready_i |=>
      rx_desc_queue_wvalid_o && $stable(rx_desc_queue_wdata_o))
    else $error("descriptor valid or payload changed while stalled");

  // Descriptor only after the last byte has left
  desc_after_data_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rx_desc_queue_wvalid_o && rx_queue_wvalid_o))
    else $error("descriptor offered while a data byte is pending");

  sda_reset_a: assert property (@(posedge clk_i) rst_i |=> ctrl_sda_o)
    else $error("SDA driven low during reset");

endmodule

bind controller_standby controller_standby_asserts u_asserts (
  .clk_i                 (clk_i),
  .rst_i                 (rst_i),
  .ctrl_sda_o            (ctrl_sda_o),
  .rx_queue_wvalid_o     (rx_queue_wvalid_o),
  .rx_queue_wready_i     (rx_queue_wready_i),
  .rx_queue_wdata_o      (rx_queue_wdata_o),
  .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid_o),
  .rx_desc_queue_wready_i(rx_desc_queue_wready_i),
  .rx_desc_queue_wdata_o (rx_desc_queue_wdata_o)
);

`default_nettype wire

// ==== tests/controller_standby_tb.sv ====
// Testbench for the standby target: bit-banged bus master, table of transfers and queue sinks
`default_nettype none
`timescale 1ns/1ps

module controller_standby_tb;
  import controller_pkg::*;

  localparam logic [6:0] OwnAddr = 7'h52;
  localparam int NumRows = 8;

  typedef struct packed {
    bus_mode_e      mode;
    logic [6:0]     addr;
    logic           rnw;
    int             n;
    logic [3:0][7:0] d;
    int             stall;
    logic           corrupt;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_i = 1'b1;
  logic        scl_m = 1'b1;
  logic        sda_m = 1'b1;
  logic        ctrl_sda_o;
  logic        ctrl_sda_i;
  logic        i3c_en_i = 1'b0;
  logic        rx_queue_wready_i = 1'b1;
  logic        rx_desc_queue_wready_i = 1'b1;
  logic        rx_queue_wvalid_o;
  logic [7:0]  rx_queue_wdata_o;
  logic        rx_desc_queue_wvalid_o;
  logic [RxDescWidth-1:0] rx_desc_queue_wdata_o;
  logic        bus_start_o;
  logic        bus_stop_o;
  logic [7:0]  bus_addr_o;
  logic        bus_addr_valid_o;

  row_t        rows [NumRows];
  logic [7:0]  data_log[$];
  logic [RxDescWidth-1:0] desc_log[$];
  logic [7:0]  addr_log[$];
  int          event_log[$];
  int          stall_mode = 0;
  logic        hold_all = 1'b0;
  logic        watch_idle = 1'b0;
  int          short_cnt = 0;
  int          desc_stall_cnt = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000000;
  logic [31:0] lcg_state = 32'h035c_b6fd;

  // Open-drain SDA
  assign ctrl_sda_i = sda_m & ctrl_sda_o;

  always #50 clk_i = ~clk_i;

  controller_standby #(.SyncStages(2)) uut (
    .clk_i(clk_i), .rst_i(rst_i),
    .ctrl_scl_i(scl_m), .ctrl_sda_i(ctrl_sda_i), .ctrl_sda_o(ctrl_sda_o),
    .i3c_en_i(i3c_en_i), .target_addr_i(OwnAddr), .t_hd_dat_i(20'd5),
    .rx_queue_wvalid_o(rx_queue_wvalid_o), .rx_queue_wready_i(rx_queue_wready_i),
    .rx_queue_wdata_o(rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid_o),
    .rx_desc_queue_wready_i(rx_desc_queue_wready_i),
    .rx_desc_queue_wdata_o(rx_desc_queue_wdata_o),
    .bus_start_o(bus_start_o), .bus_stop_o(bus_stop_o),
    .bus_addr_o(bus_addr_o), .bus_addr_valid_o(bus_addr_valid_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // Sinks and monitors, all sampled on the rising edge
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run exceeded its cycle limit");
      $display("Checks failed");
      $fatal(1);
    end
    if (rx_queue_wvalid_o && rx_queue_wready_i) data_log.push_back(rx_queue_wdata_o);
    if (rx_desc_queue_wvalid_o && rx_desc_queue_wready_i)
      desc_log.push_back(rx_desc_queue_wdata_o);
    if (bus_addr_valid_o) addr_log.push_back(bus_addr_o);
    if (bus_start_o) event_log.push_back(1);
    if (bus_stop_o) event_log.push_back(2);
    if (watch_idle && ctrl_sda_o !== 1'b1) begin
      $display("Target pulled SDA low during a transfer it should ignore");
      $display("Checks failed");
      $fatal(1);
    end
  end

  // Queue back-pressure
  always @(posedge clk_i) begin
    #1;
    if (stall_mode == 1) begin
      if (rx_queue_wvalid_o && short_cnt < 5) begin
        short_cnt = short_cnt + 1;
        rx_queue_wready_i = 1'b0;
      end else begin
        rx_queue_wready_i = 1'b1;
      end
      // Descriptor queue stalls briefly as well
      if (rx_desc_queue_wvalid_o && desc_stall_cnt < 5) begin
        desc_stall_cnt = desc_stall_cnt + 1;
        rx_desc_queue_wready_i = 1'b0;
      end else begin
        rx_desc_queue_wready_i = 1'b1;
      end
    end else begin
      rx_queue_wready_i = !hold_all;
      rx_desc_queue_wready_i = 1'b1;
    end
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // One bit, 20 clocks low then 20 high; SDA target drive sampled mid-high
  task automatic send_bit(input logic b, output logic seen);
    wait_clks(5);
    sda_m = b;
    wait_clks(15);
    scl_m = 1'b1;
    wait_clks(10);
    seen = ctrl_sda_o;
    wait_clks(10);
    scl_m = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] d, input logic ninth, output logic seen);
    logic dummy;
    for (int i = 7; i >= 0; i--) begin
      send_bit(d[i], dummy);
    end
    send_bit(ninth, seen);
  endtask

  task automatic send_start();
    sda_m = 1'b1;
    scl_m = 1'b1;
    wait_clks(20);
    sda_m = 1'b0;
    wait_clks(20);
    scl_m = 1'b0;
  endtask

  task automatic send_stop();
    wait_clks(5);
    sda_m = 1'b0;
    wait_clks(15);
    scl_m = 1'b1;
    wait_clks(20);
    sda_m = 1'b1;
    wait_clks(20);
  endtask

  task automatic set_row(input int i, input bus_mode_e mode, input logic [6:0] addr,
                         input logic rnw, input int n, input int stall, input logic corrupt);
    rows[i].mode    = mode;
    rows[i].addr    = addr;
    rows[i].rnw     = rnw;
    rows[i].n       = n;
    rows[i].stall   = stall;
    rows[i].corrupt = corrupt;
    for (int j = 0; j < 4; j++) begin
      lcg_state = lcg_next(lcg_state);
      rows[i].d[j] = lcg_state[23:16];
    end
  endtask

  initial begin
    row_t        r;
    logic        seen;
    logic        match;
    logic        ninth;
    logic [RxDescWidth-1:0] exp_desc;
    int          total;
    int          exp_bytes;

    set_row(0, i2c_mode, OwnAddr, 1'b0, 3, 0, 1'b0);
    set_row(1, i2c_mode, 7'h23,   1'b0, 2, 0, 1'b0);
    set_row(2, i2c_mode, OwnAddr, 1'b1, 1, 0, 1'b0);
    set_row(3, i3c_mode, OwnAddr, 1'b0, 4, 0, 1'b0);
    set_row(4, i3c_mode, OwnAddr, 1'b0, 2, 0, 1'b1);
    set_row(5, i2c_mode, OwnAddr, 1'b0, 3, 1, 1'b0);
    set_row(6, i2c_mode, OwnAddr, 1'b0, 3, 2, 1'b0);
    set_row(7, i3c_mode, OwnAddr, 1'b0, 2, 2, 1'b0);

    // Bus clocks per row: start, nine-bit frames, stop, drain
    total = 10;
    for (int i = 0; i < NumRows; i++) begin
      total += 40 + 360 * (rows[i].n + 1) + 60 + 80;
    end
    cycle_limit = (total * 3) / 2;

    wait_clks(3);
    rst_i = 1'b0;
    wait_clks(5);

    for (int i = 0; i < NumRows; i++) begin
      r = rows[i];
      match = (r.addr == OwnAddr) && !r.rnw;
      i3c_en_i = r.mode;
      stall_mode = r.stall;
      short_cnt = 0;
      desc_stall_cnt = 0;
      hold_all = (r.stall == 2);
      watch_idle = !match;
      data_log.delete();
      desc_log.delete();
      addr_log.delete();
      event_log.delete();

      send_start();
      send_byte({r.addr, r.rnw}, 1'b1, seen);
      check_value("address ack ctrl_sda_o", 32'(seen), match ? 32'd0 : 32'd1);
      for (int j = 0; j < r.n; j++) begin
        // T-bit gives odd parity over nine bits
        if (r.mode == i3c_mode) ninth = (r.corrupt && j == 0) ? ^r.d[j] : ~^r.d[j];
        else ninth = 1'b1;
        send_byte(r.d[j], ninth, seen);
        check_value("data ninth bit ctrl_sda_o", 32'(seen),
                    (match && r.mode == i2c_mode) ? 32'd0 : 32'd1);
      end
      send_stop();
      hold_all = 1'b0;

      if (match) begin
        while (desc_log.size() == 0) wait_clks(1);
      end
      wait_clks(60);
      watch_idle = 1'b0;

      exp_bytes = !match ? 0 : (r.stall == 2 ? 1 : r.n);
      check_value("rx_queue write count", 32'(data_log.size()), 32'(exp_bytes));
      for (int j = 0; j < exp_bytes; j++) begin
        check_value("rx_queue_wdata_o", 32'(data_log[j]), 32'(r.d[j]));
      end
      check_value("rx_desc_queue write count", 32'(desc_log.size()), match ? 32'd1 : 32'd0);
      if (match) begin
        exp_desc = {(r.stall == 2 && r.n > 1), (r.mode == i3c_mode && r.corrupt), 7'd0,
                    r.addr, 16'(r.n)};
        check_value("rx_desc_queue_wdata_o", desc_log[0], exp_desc);
      end
      check_value("bus_addr_valid_o count", 32'(addr_log.size()), 32'd1);
      check_value("bus_addr_o", 32'(addr_log[0]), 32'({r.addr, r.rnw}));
      check_value("bus event count", 32'(event_log.size()), 32'd2);
      check_value("bus_start_o order", 32'(event_log[0]), 32'd1);
      check_value("bus_stop_o order", 32'(event_log[1]), 32'd2);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/controller_pkg.sv
design/bus_event_if.sv
design/rx_byte_if.sv
design/bus_monitor.sv
design/target_fsm.sv
design/rx_queue_writer.sv
design/controller_standby.sv
tests/controller_standby_asserts.sv
tests/controller_standby_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the standby target testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module controller_standby_tb \
  --Mdir obj_dir -o controller_standby_sim \
  -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/controller_standby_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0
